// File: hw/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// direct-mapped, one word per line.
`define ICACHE_LINES 16

`define BHT_ENTRIES 32

`define RESET_PC 32'h0000_0000

`endif

// File: hw/fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    typedef enum logic [1:0] {
        OP_JAL,
        OP_JALR,
        OP_BRANCH,
        OP_OTHER
    } op_class_t;

    // 0..1 not taken, 2..3 taken.
    typedef logic [1:0] bp_cnt_t;

    localparam bp_cnt_t BP_CNT_INIT = 2'd1; // weakly not taken.

    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    function automatic op_class_t op_class(inst_t inst);
        case (inst[6:0])
            OPC_JAL:    return OP_JAL;
            OPC_JALR:   return OP_JALR;
            OPC_BRANCH: return OP_BRANCH;
            default:    return OP_OTHER;
        endcase
    endfunction

    // sign-extended jal offset.
    function automatic addr_t j_imm(inst_t inst);
        return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

    // sign-extended branch offset.
    function automatic addr_t b_imm(inst_t inst);
        return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

endpackage

// File: hw/fetch_if.sv
`timescale 1ns/1ns

interface icache_if;
    import fetch_pkg::*;

    addr_t lookup_addr;
    logic  hit;
    inst_t hit_inst;
    logic  fill_valid;
    addr_t fill_addr;
    inst_t fill_inst;

    modport fetch (
        output lookup_addr, fill_valid, fill_addr, fill_inst,
        input  hit, hit_inst
    );

    modport cache (
        input  lookup_addr, fill_valid, fill_addr, fill_inst,
        output hit, hit_inst
    );
endinterface

interface bp_if;
    import fetch_pkg::*;

    addr_t lookup_pc;
    logic  predict_taken;
    logic  upd_valid;   // driven from the back end at the top.
    addr_t upd_pc;
    logic  upd_taken;

    modport fetch (output lookup_pc, input predict_taken);

    modport predictor (
        input  lookup_pc, upd_valid, upd_pc, upd_taken,
        output predict_taken
    );
endinterface

// File: hw/inst_fetcher.sv
`timescale 1ns/1ns
`include "fetch_defs.svh"

module inst_fetcher (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 stall,
    input  logic                 redirect_valid,
    input  fetch_pkg::addr_t     redirect_pc,
    output logic                 mem_req,
    output fetch_pkg::addr_t     mem_addr,
    input  logic                 mem_ack,
    input  fetch_pkg::inst_t     mem_data,
    output logic                 dec_valid,
    output fetch_pkg::addr_t     dec_pc,
    output fetch_pkg::inst_t     dec_inst,
    output fetch_pkg::op_class_t dec_op,
    output logic                 dec_pred_taken,
    icache_if.fetch              ic,
    bp_if.fetch                  bp
);
    import fetch_pkg::*;

    typedef enum logic {S_IDLE, S_WAIT} state_t;

    state_t    state;
    addr_t     pc;
    logic      discard;     // request cut off by a redirect.
    logic      resp_valid;  // memory word held while stalled.
    inst_t     resp_data;
    inst_t     cur_inst;
    op_class_t cur_op;
    addr_t     next_pc;
    logic      pred_taken;
    logic      from_mem;
    logic      issue;
    logic      deliver;
    logic      capture;

    assign ic.lookup_addr = pc;
    assign bp.lookup_pc = pc;

    assign from_mem = (state == S_WAIT);
    assign cur_inst = from_mem ? (resp_valid ? resp_data : mem_data) : ic.hit_inst;

    always_comb begin
        cur_op = op_class(cur_inst);
        case (cur_op)
            OP_JAL: begin
                next_pc = pc + j_imm(cur_inst);
                pred_taken = 1'b1;
            end
            OP_BRANCH: begin
                pred_taken = bp.predict_taken;
                next_pc = bp.predict_taken ? pc + b_imm(cur_inst) : pc + 32'd4;
            end
            default: begin // jalr target is left to the back end.
                next_pc = pc + 32'd4;
                pred_taken = 1'b0;
            end
        endcase
    end

    // redirect wins over stall so a flush is never lost.
    always_comb begin
        issue = (state == S_IDLE) && !redirect_valid && !stall && !ic.hit;
        deliver = !redirect_valid && !stall &&
                  (((state == S_IDLE) && ic.hit) ||
                   (from_mem && !discard && (mem_ack || resp_valid)));
        capture = from_mem && mem_ack && stall && !discard && !redirect_valid;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= S_IDLE;
            pc <= `RESET_PC;
            mem_req <= 1'b0;
            discard <= 1'b0;
            resp_valid <= 1'b0;
            dec_valid <= 1'b0;
            ic.fill_valid <= 1'b0;
        end else begin
            dec_valid <= deliver;
            ic.fill_valid <= deliver && from_mem;

            if (redirect_valid) begin
                pc <= redirect_pc;
            end else if (deliver) begin
                pc <= next_pc;
            end

            if (issue) begin
                mem_req <= 1'b1;
            end else if (mem_ack) begin
                mem_req <= 1'b0;
            end

            case (state)
                S_IDLE: begin
                    if (issue) state <= S_WAIT;
                end
                S_WAIT: begin
                    if (mem_ack || resp_valid) begin
                        if (deliver || discard || redirect_valid) begin
                            state <= S_IDLE;
                            resp_valid <= 1'b0;
                            discard <= 1'b0;
                        end else begin
                            resp_valid <= 1'b1; // hold until stall drops.
                        end
                    end else if (redirect_valid) begin
                        discard <= 1'b1; // keep mem_req, drop the answer.
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (deliver) begin
            dec_pc <= pc;
            dec_inst <= cur_inst;
            dec_op <= cur_op;
            dec_pred_taken <= pred_taken;
        end
        if (deliver && from_mem) begin
            ic.fill_addr <= pc;
            ic.fill_inst <= cur_inst;
        end
        if (issue) mem_addr <= pc;
        if (capture) resp_data <= mem_data;
    end

    a_mem_hold: assert property (@(posedge clk_in) disable iff (rst_in)
        mem_req && !mem_ack |=> mem_req && $stable(mem_addr));

    a_quiet_reset: assert property (@(posedge clk_in)
        rst_in |=> !dec_valid && !ic.fill_valid);

    a_ack_with_req: assert property (@(posedge clk_in) disable iff (rst_in)
        mem_ack |-> mem_req);

endmodule

// File: hw/inst_cache.sv
`timescale 1ns/1ns
`include "fetch_defs.svh"

module inst_cache (
    input  logic    clk_in,
    input  logic    rst_in,
    icache_if.cache ic
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(`ICACHE_LINES);
    localparam int TAG_W = $bits(addr_t) - IDX_W - 2;

    logic [TAG_W-1:0]         tag_mem  [`ICACHE_LINES];
    inst_t                    data_mem [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] valid_q;
    logic [IDX_W-1:0]         rd_idx;
    logic [IDX_W-1:0]         wr_idx;
    logic [TAG_W-1:0]         rd_tag;
    logic [TAG_W-1:0]         wr_tag;

    // word offset bits 1..0 are skipped.
    assign rd_idx = ic.lookup_addr[IDX_W+1:2];
    assign rd_tag = ic.lookup_addr[$bits(addr_t)-1:IDX_W+2];
    assign wr_idx = ic.fill_addr[IDX_W+1:2];
    assign wr_tag = ic.fill_addr[$bits(addr_t)-1:IDX_W+2];

    assign ic.hit = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign ic.hit_inst = data_mem[rd_idx];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_q <= '0;
        end else if (ic.fill_valid) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (ic.fill_valid) begin
            tag_mem[wr_idx] <= wr_tag;
            data_mem[wr_idx] <= ic.fill_inst;
        end
    end

    a_fill_aligned: assert property (@(posedge clk_in) disable iff (rst_in)
        ic.fill_valid |-> (ic.fill_addr[1:0] == 2'b00));

endmodule

// File: hw/branch_predictor.sv
`timescale 1ns/1ns
`include "fetch_defs.svh"

module branch_predictor (
    input  logic       clk_in,
    input  logic       rst_in,
    bp_if.predictor    bp
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(`BHT_ENTRIES);

    bp_cnt_t          cnt_q [`BHT_ENTRIES];
    bp_cnt_t          old_cnt;
    bp_cnt_t          upd_cnt;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign rd_idx = bp.lookup_pc[IDX_W+1:2];
    assign wr_idx = bp.upd_pc[IDX_W+1:2];

    assign bp.predict_taken = cnt_q[rd_idx][1]; // upper bit means taken.

    // saturate at 0 and 3.
    always_comb begin
        old_cnt = cnt_q[wr_idx];
        upd_cnt = old_cnt;
        if (bp.upd_taken && old_cnt != 2'd3) begin
            upd_cnt = old_cnt + 2'd1;
        end else if (!bp.upd_taken && old_cnt != 2'd0) begin
            upd_cnt = old_cnt - 2'd1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                cnt_q[i] <= BP_CNT_INIT;
            end
        end else if (bp.upd_valid) begin
            cnt_q[wr_idx] <= upd_cnt;
        end
    end

endmodule

// File: hw/fetch_top.sv
`timescale 1ns/1ns

module fetch_top (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 stall,
    input  logic                 redirect_valid,
    input  fetch_pkg::addr_t     redirect_pc,
    output logic                 mem_req,
    output fetch_pkg::addr_t     mem_addr,
    input  logic                 mem_ack,
    input  fetch_pkg::inst_t     mem_data,
    output logic                 dec_valid,
    output fetch_pkg::addr_t     dec_pc,
    output fetch_pkg::inst_t     dec_inst,
    output fetch_pkg::op_class_t dec_op,
    output logic                 dec_pred_taken,
    input  logic                 bp_upd_valid,
    input  fetch_pkg::addr_t     bp_upd_pc,
    input  logic                 bp_upd_taken
);

    icache_if ic_bus ();
    bp_if     bp_bus ();

    // back-end training enters here.
    assign bp_bus.upd_valid = bp_upd_valid;
    assign bp_bus.upd_pc = bp_upd_pc;
    assign bp_bus.upd_taken = bp_upd_taken;

    inst_fetcher i_fetcher (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .stall          (stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_ack        (mem_ack),
        .mem_data       (mem_data),
        .dec_valid      (dec_valid),
        .dec_pc         (dec_pc),
        .dec_inst       (dec_inst),
        .dec_op         (dec_op),
        .dec_pred_taken (dec_pred_taken),
        .ic             (ic_bus.fetch),
        .bp             (bp_bus.fetch)
    );

    inst_cache i_cache (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .ic     (ic_bus.cache)
    );

    branch_predictor i_predictor (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .bp     (bp_bus.predictor)
    );

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_in,
    output logic rst_in
);
    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in; // 10 ns period.
    end

    initial begin
        rst_in = 1'b1;
        repeat (2) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
    end
endmodule

// File: test/fetch_tb.sv
`timescale 1ns/1ns
`include "fetch_defs.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam int    WAIT_LIMIT = 200;
    localparam inst_t JALR_WORD = 32'h0000_8067; // jalr x0, 0(x1).

    logic      clk_in;
    logic      rst_in;
    logic      stall;
    logic      redirect_valid;
    addr_t     redirect_pc;
    logic      mem_req;
    addr_t     mem_addr;
    logic      mem_ack;
    inst_t     mem_data;
    logic      dec_valid;
    addr_t     dec_pc;
    inst_t     dec_inst;
    op_class_t dec_op;
    logic      dec_pred_taken;
    logic      bp_upd_valid;
    addr_t     bp_upd_pc;
    logic      bp_upd_taken;

    inst_t     mem [512];
    integer    seed = 81845;
    int        req_count;
    int        errors;
    int        checks;
    int        tests;
    int        base;       // first queue entry of the current test.

    addr_t     got_pc [$];
    inst_t     got_inst [$];
    op_class_t got_op [$];
    logic      got_pred [$];

    tb_clock_gen i_clk (.clk_in(clk_in), .rst_in(rst_in));

    fetch_top i_dut (.*);

    // one request at a time, answered after 1 to 4 cycles.
    initial begin
        int unsigned lat;
        mem_ack = 1'b0;
        mem_data = '0;
        req_count = 0;
        forever begin
            @(posedge clk_in);
            #1;
            if (mem_req && !rst_in) begin
                req_count++;
                lat = 1 + ($unsigned($random(seed)) % 4);
                repeat (lat - 1) @(posedge clk_in);
                #1;
                mem_ack = 1'b1;
                mem_data = mem[mem_addr[10:2]];
                @(posedge clk_in);
                #1;
                mem_ack = 1'b0;
            end
        end
    end

    always @(negedge clk_in) begin
        if (dec_valid) begin
            got_pc.push_back(dec_pc);
            got_inst.push_back(dec_inst);
            got_op.push_back(dec_op);
            got_pred.push_back(dec_pred_taken);
        end
    end

    function automatic inst_t alu_word(addr_t a);
        return {a[11:0], 5'd0, 3'b000, 5'd1, 7'b0010011}; // addi x1, x0, imm.
    endfunction

    function automatic inst_t enc_jal(addr_t off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
    endfunction

    function automatic inst_t enc_beq(addr_t off);
        return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic inst_t word_at(addr_t a);
        return mem[a[10:2]];
    endfunction

    task automatic put_word(addr_t a, inst_t w);
        mem[a[10:2]] = w;
    endtask

    task automatic load_program();
        for (int i = 0; i < 512; i++) begin
            put_word(addr_t'(i * 4), alu_word(addr_t'(i * 4)));
        end
        put_word(32'h010, enc_jal(32'd16));
        put_word(32'h020, JALR_WORD);
        put_word(32'h024, enc_jal(32'd0)); // park loops on itself.
        put_word(32'h100, enc_beq(32'h20));
        put_word(32'h104, enc_jal(32'd0));
        put_word(32'h120, enc_jal(32'd0));
        put_word(32'h20c, enc_jal(-32'd12));
        put_word(32'h384, enc_jal(32'd0));
        put_word(32'h420, enc_jal(32'd0));
    endtask

    task automatic check_addr(string name, addr_t exp, addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_inst(string name, inst_t exp, inst_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_op(string name, op_class_t exp, op_class_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic note_failure(string what);
        checks++;
        errors++;
        $display("%s", what);
    endtask

    task automatic check_decode(int i, addr_t pc, inst_t inst, op_class_t op, logic pred);
        check_addr("dec_pc", pc, got_pc[base + i]);
        check_inst("dec_inst", inst, got_inst[base + i]);
        check_op("dec_op", op, got_op[base + i]);
        check_bit("dec_pred_taken", pred, got_pred[base + i]);
    endtask

    task automatic abort_run(string why);
        $display("timeout: %s", why);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic next_cycle();
        @(posedge clk_in);
        #1;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_in !== 1'b0 && cycles < 10) begin
            next_cycle();
            cycles++;
        end
        if (rst_in !== 1'b0) abort_run("reset never released");
    endtask

    task automatic wait_decodes(int n);
        int cycles;
        cycles = 0;
        while (got_pc.size() < base + n && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (got_pc.size() < base + n) abort_run("decoder output did not arrive");
    endtask

    task automatic wait_mem_req();
        int cycles;
        cycles = 0;
        while (mem_req !== 1'b1 && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (mem_req !== 1'b1) abort_run("memory request never raised");
    endtask

    task automatic redirect_to(addr_t a);
        redirect_valid = 1'b1;
        redirect_pc = a;
        next_cycle();
        redirect_valid = 1'b0;
        base = got_pc.size(); // older entries belong to the old path.
    endtask

    task automatic train_taken(addr_t a, int n);
        bp_upd_valid = 1'b1;
        bp_upd_pc = a;
        bp_upd_taken = 1'b1;
        repeat (n) next_cycle();
        bp_upd_valid = 1'b0;
    endtask

    task automatic finish_test(string name, int err_before);
        tests++;
        $display("test %s: %0d errors", name, errors - err_before);
    endtask

    task automatic test_sequential();
        int e0;
        e0 = errors;
        wait_decodes(4);
        for (int i = 0; i < 4; i++) begin
            check_decode(i, `RESET_PC + addr_t'(4 * i), word_at(addr_t'(4 * i)), OP_OTHER, 1'b0);
        end
        finish_test("sequential fetch", e0);
    endtask

    task automatic test_jumps();
        int e0;
        e0 = errors;
        wait_decodes(7);
        check_decode(4, 32'h010, enc_jal(32'd16), OP_JAL, 1'b1);
        check_decode(5, 32'h010 + 32'd16, JALR_WORD, OP_JALR, 1'b0);
        check_decode(6, 32'h020 + 32'd4, enc_jal(32'd0), OP_JAL, 1'b1);
        finish_test("jumps", e0);
    endtask

    task automatic test_branch();
        int e0;
        e0 = errors;
        redirect_to(32'h100);
        wait_decodes(2);
        check_decode(0, 32'h100, enc_beq(32'h20), OP_BRANCH, 1'b0);
        check_decode(1, 32'h104, enc_jal(32'd0), OP_JAL, 1'b1);
        train_taken(32'h100, 2); // counter 1 -> 3.
        redirect_to(32'h100);
        wait_decodes(2);
        check_decode(0, 32'h100, enc_beq(32'h20), OP_BRANCH, 1'b1);
        check_decode(1, 32'h100 + 32'h20, enc_jal(32'd0), OP_JAL, 1'b1);
        finish_test("branch prediction", e0);
    endtask

    task automatic test_cache_reuse();
        int e0;
        int reqs;
        e0 = errors;
        redirect_to(32'h200);
        wait_decodes(4);
        reqs = req_count;
        wait_decodes(8);
        for (int p = 0; p < 2; p++) begin // same loop body on both passes.
            for (int i = 0; i < 3; i++) begin
                check_decode(4 * p + i, 32'h200 + addr_t'(4 * i),
                             word_at(32'h200 + addr_t'(4 * i)), OP_OTHER, 1'b0);
            end
            check_decode(4 * p + 3, 32'h20c, enc_jal(-32'd12), OP_JAL, 1'b1);
        end
        if (req_count != reqs) note_failure("memory requests grew on the second loop pass");
        finish_test("cache reuse", e0);
    endtask

    task automatic test_redirect_miss();
        int e0;
        int first;
        e0 = errors;
        redirect_to(32'h300);
        first = base;
        wait_mem_req();
        check_addr("mem_addr", 32'h300, mem_addr);
        redirect_to(32'h380); // lands while the miss is outstanding.
        wait_decodes(3);
        for (int i = first; i < got_inst.size(); i++) begin
            if (got_inst[i] === word_at(32'h300)) begin
                note_failure("instruction delivered from the cut-off request");
            end
        end
        check_decode(0, 32'h380, word_at(32'h380), OP_OTHER, 1'b0);
        check_decode(1, 32'h384, enc_jal(32'd0), OP_JAL, 1'b1);
        check_decode(2, 32'h384, enc_jal(32'd0), OP_JAL, 1'b1);
        finish_test("redirect during miss", e0);
    endtask

    task automatic test_stall();
        int e0;
        int held;
        e0 = errors;
        redirect_to(32'h400);
        wait_decodes(2);
        stall = 1'b1;
        next_cycle();
        held = got_pc.size();
        repeat (5) next_cycle();
        if (got_pc.size() != held) note_failure("decoder output appeared while stalled");
        stall = 1'b0;
        wait_decodes(8);
        for (int i = 0; i < 8; i++) begin
            check_decode(i, 32'h400 + addr_t'(4 * i), word_at(32'h400 + addr_t'(4 * i)),
                         OP_OTHER, 1'b0);
        end
        finish_test("stall", e0);
    endtask

    initial begin
        stall = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        bp_upd_valid = 1'b0;
        bp_upd_pc = '0;
        bp_upd_taken = 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        base = 0;
        load_program();
        wait_reset_release();
        test_sequential();
        test_jumps();
        test_branch();
        test_cache_reuse();
        test_redirect_miss();
        test_stall();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end
endmodule

// File: all.f
+incdir+hw
hw/fetch_pkg.sv
hw/fetch_if.sv
hw/inst_fetcher.sv
hw/inst_cache.sv
hw/branch_predictor.sv
hw/fetch_top.sv
test/tb_clock_gen.sv
test/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module fetch_tb -f all.f -o fetch_sim &&
./obj_dir/fetch_sim | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
